// ==== hdl/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // Bus widths
    localparam int ADDR_W = 16;                     // Byte address
    localparam int DATA_W = 32;                     // Data bus
    localparam int SEL_W  = DATA_W / 8;             // One select per byte lane
    localparam int BYTE_W = DATA_W / SEL_W;         // Lane width

    // Bank geometry
    localparam int N_BANKS         = 4;             // Interleaved RAM banks
    localparam int BANK_BITS       = 2;             // Bank index width
    localparam int BANK_LSB        = 2;             // Bank index sits above byte offset
    localparam int BANK_DEPTH_BITS = 8;             // Word index width in a bank
    localparam int BANK_DEPTH      = 1 << BANK_DEPTH_BITS;  // Words per bank
    localparam int WORD_LSB        = BANK_LSB + BANK_BITS;  // Word index starts at bit 4

    // Address bits above WORD_LSB + BANK_DEPTH_BITS - 1 are not decoded,
    // so the whole memory repeats every 4 KB

    // Master to slave request
    typedef struct packed {
        logic [ADDR_W-1:0] adr;                     // Byte address
        logic [DATA_W-1:0] dat;                     // Write data
        logic              we;                      // Write enable
        logic [SEL_W-1:0]  sel;                     // Byte lane enables
        logic              stb;                     // Strobe
        logic              cyc;                     // Bus cycle
    } wb_req_t;

    // Slave to master response
    typedef struct packed {
        logic [DATA_W-1:0] dat;                     // Read data
        logic              ack;                     // Single cycle ack
    } wb_rsp_t;

    // Which bank an address falls into
    typedef logic [BANK_BITS-1:0] bank_idx_t;

endpackage

`default_nettype wire

// ==== hdl/arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module arbiter #(
    parameter bit ARB_ROUND_ROBIN = 1'b0            // 1 rotates priority, 0 favours index 0
) (
    input  wire        clk,
    input  wire        rst_i,
    input  wire  [1:0] request_i,                   // One bit per requester
    output logic [1:0] grant_o,                     // Registered one-hot grant
    output logic       grant_valid_o                // Grant holds a winner
);

    logic [1:0] grant_q;                            // Current owner
    logic       valid_q;                            // Owner present
    logic [1:0] last_q;                             // Winner of last decision
    logic [1:0] masked_req;                         // Requests minus last winner
    logic [1:0] pick;                               // Next winner
    logic       hold;                               // Owner still requesting

    // Blocking grant stays while the owner keeps its request up
    assign hold = valid_q && |(grant_q & request_i);

    // Last winner drops to lowest priority
    assign masked_req = request_i & ~last_q;

    always_comb begin
        pick = 2'b00;                               // Nobody asking
        if (ARB_ROUND_ROBIN && |masked_req) begin
            pick = masked_req[0] ? 2'b01 : 2'b10;   // Rotated choice
        end else if (request_i[0]) begin
            pick = 2'b01;                           // Index 0 first
        end else if (request_i[1]) begin
            pick = 2'b10;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            grant_q <= 2'b00;
            valid_q <= 1'b0;
            last_q  <= 2'b00;                       // No history after reset
        end else if (!hold) begin
            grant_q <= pick;                        // Release or re-decide
            valid_q <= |request_i;
            if (|request_i) begin
                last_q <= pick;                     // Remember for rotation
            end
        end
    end

    assign grant_o       = grant_q;
    assign grant_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== hdl/arbiter2_wb.sv ====
`timescale 1ns/100ps
`default_nettype none

module arbiter2_wb #(
    parameter bit ARB_ROUND_ROBIN = 1'b0            // Passed to the arbiter core
) (
    input  wire                  clk,
    input  wire                  rst_i,

    input  wire wb_pkg::wb_req_t m0_req_i,          // Master 0 request
    input  wire wb_pkg::wb_req_t m1_req_i,          // Master 1 request
    output wb_pkg::wb_rsp_t      m0_rsp_o,          // Master 0 response
    output wb_pkg::wb_rsp_t      m1_rsp_o,          // Master 1 response

    output wb_pkg::wb_req_t      bus_req_o,         // Shared slave side request
    input  wire wb_pkg::wb_rsp_t bus_rsp_i          // Shared slave side response
);

    logic [1:0] request;                            // cyc of each master
    logic [1:0] grant;                              // One-hot owner
    logic       grant_valid;                        // Owner present
    logic       m0_sel;                             // Master 0 owns bus
    logic       m1_sel;                             // Master 1 owns bus

    // A master asks for the bus by raising cyc
    assign request = {m1_req_i.cyc, m0_req_i.cyc};

    assign m0_sel = grant[0] & grant_valid;
    assign m1_sel = grant[1] & grant_valid;

    // Granted master drives the bus, idle request is all zero
    always_comb begin
        bus_req_o = '0;
        if (m0_sel) begin
            bus_req_o = m0_req_i;
        end else if (m1_sel) begin
            bus_req_o = m1_req_i;
        end
    end

    // Read data fans out, ack only reaches the owner
    assign m0_rsp_o = '{dat: bus_rsp_i.dat, ack: bus_rsp_i.ack & m0_sel};
    assign m1_rsp_o = '{dat: bus_rsp_i.dat, ack: bus_rsp_i.ack & m1_sel};

    arbiter #(
        .ARB_ROUND_ROBIN (ARB_ROUND_ROBIN)
    ) i_arbiter (
        .clk           (clk),
        .rst_i         (rst_i),
        .request_i     (request),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

endmodule

`default_nettype wire

// ==== hdl/wb_bank_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_bank_decoder (
    input  wire wb_pkg::wb_req_t                      bus_req_i,   // Granted request
    output wb_pkg::wb_req_t [wb_pkg::N_BANKS-1:0]     bank_req_o,  // Per-bank requests
    output wb_pkg::bank_idx_t                         sel_bank_o   // Addressed bank
);
    import wb_pkg::*;

    bank_idx_t idx;                                 // Decoded bank number
    logic      hit;                                 // Loop bank is addressed

    // Word interleave on address bits 3:2
    assign idx        = bus_req_i.adr[BANK_LSB +: BANK_BITS];
    assign sel_bank_o = idx;

    always_comb begin
        hit = 1'b0;
        for (int b = 0; b < N_BANKS; b++) begin
            hit           = (idx == bank_idx_t'(b));
            bank_req_o[b] = bus_req_i;              // Shared adr, dat, we, sel
            bank_req_o[b].stb = bus_req_i.stb & hit;  // Strobe only the target
            bank_req_o[b].cyc = bus_req_i.cyc & hit;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wb_ram_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ram_bank (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire wb_pkg::wb_req_t req_i,             // Request from decoder
    output wb_pkg::wb_rsp_t      rsp_o              // Registered response
);
    import wb_pkg::*;

    logic [DATA_W-1:0]          mem [BANK_DEPTH];   // Word storage
    logic [BANK_DEPTH_BITS-1:0] word_idx;           // Word within bank
    logic [DATA_W-1:0]          rdata_q;            // Read data register
    logic                       ack_q;              // One cycle ack
    logic                       access;             // Fresh strobe this cycle

    // Bits 11:4 pick the word, upper bits alias
    assign word_idx = req_i.adr[WORD_LSB +: BANK_DEPTH_BITS];

    // ack high blocks a second access for the same strobe
    assign access = req_i.cyc && req_i.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (req_i.we) begin
                for (int i = 0; i < SEL_W; i++) begin
                    if (req_i.sel[i]) begin
                        mem[word_idx][i*BYTE_W +: BYTE_W] <= req_i.dat[i*BYTE_W +: BYTE_W];
                    end
                end
            end
            rdata_q <= mem[word_idx];               // Old contents on a write
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;                        // Ack one clock after strobe
        end
    end

    assign rsp_o = '{dat: rdata_q, ack: ack_q};

endmodule

`default_nettype wire

// ==== hdl/wb_resp_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_resp_collect (
    input  wire                                   clk,
    input  wire                                   rst_i,
    input  wire wb_pkg::bank_idx_t                sel_bank_i,  // Bank under strobe
    input  wire wb_pkg::wb_rsp_t [wb_pkg::N_BANKS-1:0] bank_rsp_i,  // All bank responses
    output wb_pkg::wb_rsp_t                       bus_rsp_o    // Merged response
);
    import wb_pkg::*;

    bank_idx_t idx_q;                               // Bank strobed last cycle
    logic      any_ack;                             // OR of bank acks

    // Banks answer one clock after the strobe, so lag the index by one
    always_ff @(posedge clk) begin
        if (rst_i) begin
            idx_q <= '0;
        end else begin
            idx_q <= sel_bank_i;
        end
    end

    always_comb begin
        any_ack = 1'b0;
        for (int b = 0; b < N_BANKS; b++) begin
            any_ack = any_ack | bank_rsp_i[b].ack;  // At most one bank acks
        end
    end

    assign bus_rsp_o = '{dat: bank_rsp_i[idx_q].dat, ack: any_ack};

endmodule

`default_nettype wire

// ==== hdl/wb_ram_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ram_sys (
    input  wire                  clk,
    input  wire                  rst_i,
    input  wire wb_pkg::wb_req_t m0_req_i,          // Master 0 request
    input  wire wb_pkg::wb_req_t m1_req_i,          // Master 1 request
    output wb_pkg::wb_rsp_t      m0_rsp_o,          // Master 0 response
    output wb_pkg::wb_rsp_t      m1_rsp_o           // Master 1 response
);
    import wb_pkg::*;

    wb_req_t               bus_req;                 // Arbiter to decoder
    wb_rsp_t               bus_rsp;                 // Collector to arbiter
    wb_req_t [N_BANKS-1:0] bank_req;                // Decoder to banks
    wb_rsp_t [N_BANKS-1:0] bank_rsp;                // Banks to collector
    bank_idx_t             sel_bank;                // Addressed bank

    arbiter2_wb #(
        .ARB_ROUND_ROBIN (1'b1)                     // Alternate under contention
    ) i_arb (
        .clk       (clk),
        .rst_i     (rst_i),
        .m0_req_i  (m0_req_i),
        .m1_req_i  (m1_req_i),
        .m0_rsp_o  (m0_rsp_o),
        .m1_rsp_o  (m1_rsp_o),
        .bus_req_o (bus_req),
        .bus_rsp_i (bus_rsp)
    );

    wb_bank_decoder i_dec (
        .bus_req_i  (bus_req),
        .bank_req_o (bank_req),
        .sel_bank_o (sel_bank)
    );

    for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
        wb_ram_bank i_bank (
            .clk   (clk),
            .rst_i (rst_i),
            .req_i (bank_req[b]),
            .rsp_o (bank_rsp[b])
        );
    end

    wb_resp_collect i_collect (
        .clk        (clk),
        .rst_i      (rst_i),
        .sel_bank_i (sel_bank),
        .bank_rsp_i (bank_rsp),
        .bus_rsp_o  (bus_rsp)
    );

endmodule

`default_nettype wire

// ==== verification/wb_ram_sys_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_ram_sys_props (
    input wire       clk,
    input wire       rst_i,
    input wire [1:0] grant_i,                       // Arbiter core grant
    input wire       m0_cyc_i,
    input wire       m1_cyc_i,
    input wire       m0_ack_i,
    input wire       m1_ack_i
);

    // At most one owner
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst_i)
        $onehot0(grant_i))
        else $error("Arbiter grant is not one-hot or zero");

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst_i)
        !(m0_ack_i && !m0_cyc_i) && !(m1_ack_i && !m1_cyc_i))
        else $error("Master saw ack without cyc");

    // Single cycle acks
    a_m0_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
        m0_ack_i |=> !m0_ack_i)
        else $error("Master 0 ack high for two cycles");

    a_m1_ack_pulse: assert property (@(posedge clk) disable iff (rst_i)
        m1_ack_i |=> !m1_ack_i)
        else $error("Master 1 ack high for two cycles");

endmodule

bind arbiter2_wb wb_ram_sys_props i_props (
    .clk       (clk),
    .rst_i     (rst_i),
    .grant_i   (grant),
    .m0_cyc_i  (m0_req_i.cyc),
    .m1_cyc_i  (m1_req_i.cyc),
    .m0_ack_i  (m0_rsp_o.ack),
    .m1_ack_i  (m1_rsp_o.ack)
);

`default_nettype wire

// ==== verification/tb_wb_ram_sys.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wb_ram_sys;
    import wb_pkg::*;

    logic        clk;
    logic        rst_i;
    wb_req_t     m0_req;                            // Master 0 drive
    wb_req_t     m1_req;                            // Master 1 drive
    wb_rsp_t     m0_rsp;
    wb_rsp_t     m1_rsp;

    logic [31:0] vec [384];                         // Up to 64 lines of 6 words
    int          n_lines;                           // Lines before the end marker
    int          limit;                             // Cycle budget for the run
    int          cycles;                            // Clocks since start
    int          ack_cnt [2];                       // Acks seen per master
    int          op_cnt [2];                        // Transfers finished per master
    int          ack_order [$];                     // Owner of each ack in turn
    logic [31:0] rng;                               // Gap generator state

    wb_ram_sys i_dut (
        .clk      (clk),
        .rst_i    (rst_i),
        .m0_req_i (m0_req),
        .m1_req_i (m1_req),
        .m0_rsp_o (m0_rsp),
        .m1_rsp_o (m1_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                     // 40 ns period
    end

    // Count every ack to catch a second ack for one strobe
    always @(negedge clk) begin
        if (!rst_i) begin
            if (m0_rsp.ack) begin
                ack_cnt[0] = ack_cnt[0] + 1;
            end
            if (m1_rsp.ack) begin
                ack_cnt[1] = ack_cnt[1] + 1;
            end
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: run did not finish within %0d clock cycles", limit);
            $display("=== FAIL ===");
            $fatal(1, "Simulation stopped by timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic drive_master(input int m, input wb_req_t r);
        if (m == 0) begin
            m0_req <= r;
        end else begin
            m1_req <= r;
        end
    endtask

    function automatic logic master_ack(input int m);
        return (m == 0) ? m0_rsp.ack : m1_rsp.ack;
    endfunction

    // One classic single transfer that blocks until the ack
    task automatic bus_access(input int m, input logic wr, input logic [15:0] addr,
                              input logic [31:0] wdata, input logic [3:0] sel_mask,
                              output logic [31:0] rdata);
        wb_req_t r;
        r.adr = addr;
        r.dat = wdata;
        r.we  = wr;
        r.sel = sel_mask;
        r.stb = 1'b1;
        r.cyc = 1'b1;
        @(posedge clk);
        drive_master(m, r);                         // cyc and stb rise together
        do begin
            @(negedge clk);                         // Sample away from the edge
        end while (!master_ack(m));
        rdata = (m == 0) ? m0_rsp.dat : m1_rsp.dat;
        ack_order.push_back(m);
        op_cnt[m] = op_cnt[m] + 1;
        @(posedge clk);
        drive_master(m, '0);                        // Drop stb and cyc after ack
    endtask

    initial begin
        logic [31:0] rd0;
        logic [31:0] rd1;
        logic [31:0] w [6];                         // Fields of the current line
        int          n;
        rst_i  = 1'b1;
        m0_req = '0;
        m1_req = '0;
        rng    = 32'h685d_3547;
        $readmemh("verification/wb_input.txt", vec);
        n_lines = 0;
        while (n_lines < 64 && vec[6*n_lines] != 32'hff) begin
            n_lines++;                              // ff in master column ends the list
        end
        limit = 16 * n_lines + 100;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);
        check_value("m0 ack after reset", 32'(m0_rsp.ack), 32'd0);
        check_value("m1 ack after reset", 32'(m1_rsp.ack), 32'd0);

        for (int i = 0; i < n_lines; i++) begin
            for (int k = 0; k < 6; k++) begin
                w[k] = vec[6*i + k];
            end
            if (w[0] == 32'd2) begin
                fork                                // Same transfer from both masters
                    bus_access(0, w[1][0], w[2][15:0], w[3], w[4][3:0], rd0);
                    bus_access(1, w[1][0], w[2][15:0], w[3], w[4][3:0], rd1);
                join
                if (!w[1][0]) begin
                    check_value($sformatf("line %0d master 0 read", i), rd0, w[5]);
                    check_value($sformatf("line %0d master 1 read", i), rd1, w[5]);
                end
                n = ack_order.size();
                if (n > 2) begin                    // Last served master goes second
                    check_value($sformatf("line %0d ack order", i),
                                ack_order[n-2], 32'(1 - ack_order[n-3]));
                end
            end else begin
                bus_access(w[0], w[1][0], w[2][15:0], w[3], w[4][3:0], rd0);
                if (!w[1][0]) begin
                    check_value($sformatf("line %0d read", i), rd0, w[5]);
                end
            end
            rng = xorshift32(rng);
            repeat (rng[1:0]) @(posedge clk);       // Idle gap of 0 to 3 cycles
        end

        repeat (4) @(posedge clk);                  // Let any stray ack show up
        @(negedge clk);
        check_value("master 0 ack count", ack_cnt[0], op_cnt[0]);
        check_value("master 1 ack count", ack_cnt[1], op_cnt[1]);
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/wb_input.txt ====
// master we adr dat sel exp, all hex; master 2 = both masters at once, ff ends the list
// exp is the expected read data, ignored on writes
// Full word write and read back, also across masters
0 1 0000 11111111 f 0
0 0 0000 0 f 11111111
1 1 0010 22222222 f 0
1 0 0010 0 f 22222222
0 0 0010 0 f 22222222
1 0 0000 0 f 11111111
// Partial writes merge with old bytes
0 1 0020 a1b2c3d4 f 0
0 1 0020 000000ee 1 0
1 0 0020 0 f a1b2c3ee
1 1 0020 5566ffff c 0
0 0 0020 0 f 5566c3ee
0 1 0020 00770000 4 0
1 0 0020 0 f 5577c3ee
1 1 0020 0000aa00 2 0
0 0 0020 0 f 5577aaee
// One word in each of the four banks
0 1 0100 b0000000 f 0
1 1 0104 b1111111 f 0
0 1 0108 b2222222 f 0
1 1 010c b3333333 f 0
1 0 0100 0 f b0000000
0 0 0104 0 f b1111111
1 0 0108 0 f b2222222
0 0 010c 0 f b3333333
// Aliases above bit 11
0 0 1100 0 f b0000000
1 0 f104 0 f b1111111
0 1 2108 c2c2c2c2 f 0
1 0 0108 0 f c2c2c2c2
// Same bank, next word
1 1 0114 d1d1d1d1 f 0
0 0 0104 0 f b1111111
0 0 0114 0 f d1d1d1d1
// Contention from both masters
2 1 0200 e0e0e0e0 f 0
2 0 0200 0 f e0e0e0e0
2 0 0100 0 f b0000000
2 0 010c 0 f b3333333
2 0 0020 0 f 5577aaee
2 1 0ffc 12345678 f 0
2 0 0ffc 0 f 12345678
2 0 1ffc 0 f 12345678
ff 0 0 0 0 0

// ==== src.f ====
hdl/wb_pkg.sv
hdl/arbiter.sv
hdl/arbiter2_wb.sv
hdl/wb_bank_decoder.sv
hdl/wb_ram_bank.sv
hdl/wb_resp_collect.sv
hdl/wb_ram_sys.sv
verification/wb_ram_sys_props.sv
verification/tb_wb_ram_sys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_wb_ram_sys \
    -f src.f \
    -o sim_wb_ram_sys

status=0
./obj_dir/sim_wb_ram_sys > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"
